// ==== logic/fifo_geometry_pkg.sv ====
`default_nettype none

// storage and admission side definitions
package fifo_geometry_pkg;

    // admission FSM of the write side
    // store keeps writing beats at the current pointer,
    // drop swallows beats until the frame's last beat
    typedef enum logic [0:0] {
        ADMIT_STORE = 1'b0,
        ADMIT_DROP  = 1'b1
    } admit_state_t;

endpackage

`default_nettype wire

// ==== logic/frame_status_pkg.sv ====
`default_nettype none

// frame outcome reporting
package frame_status_pkg;

    // outcome of one frame at its last beat
    // values 1..3 also index the per-outcome status vectors
    typedef enum logic [1:0] {
        EV_NONE     = 2'd0,
        EV_GOOD     = 2'd1,
        EV_BAD      = 2'd2,
        EV_OVERFLOW = 2'd3
    } frame_event_t;

    // width of each outcome counter
    localparam int STAT_WIDTH = 16;

endpackage

`default_nettype wire

// ==== logic/frame_admit.sv ====
`default_nettype none

module frame_admit #(
    parameter int ADDR_WIDTH     = 12,
    parameter int DATA_WIDTH     = 8,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  wire                            input_clk,
    input  wire                            in_rst,
    input  wire [DATA_WIDTH-1:0]           in_tdata,
    input  wire                            in_tvalid,
    output logic                           in_tready,
    input  wire                            in_tlast,
    input  wire                            in_tuser,
    input  wire [ADDR_WIDTH:0]             rd_ptr_gray_sync,
    output logic                           wr_en,
    output logic [ADDR_WIDTH-1:0]          wr_addr,
    output logic [DATA_WIDTH:0]            wr_data,
    output logic [ADDR_WIDTH:0]            wr_ptr_gray,
    output frame_status_pkg::frame_event_t in_event,
    output logic                           tog_good,
    output logic                           tog_bad,
    output logic                           tog_overflow
);
    import fifo_geometry_pkg::*;
    import frame_status_pkg::*;

    // committed pointer and pointer of the frame in progress
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] cur_ptr;
    logic [ADDR_WIDTH:0] cur_inc;
    logic [ADDR_WIDTH:0] cur_gray;
    logic                admit_en;
    logic                full;
    logic                frame_ovf;
    logic                accept;
    admit_state_t        state;
    frame_event_t        event_next;

    assign cur_inc  = cur_ptr + 1'b1;
    assign cur_gray = cur_ptr ^ (cur_ptr >> 1);

    // full when the gray pointers differ in the two top bits only
    assign full = cur_gray == {~rd_ptr_gray_sync[ADDR_WIDTH:ADDR_WIDTH-1],
                               rd_ptr_gray_sync[ADDR_WIDTH-2:0]};
    // frame in progress already fills the whole memory
    assign frame_ovf = (cur_ptr[ADDR_WIDTH] != wr_ptr[ADDR_WIDTH]) &&
                       (cur_ptr[ADDR_WIDTH-1:0] == wr_ptr[ADDR_WIDTH-1:0]);

    // an oversized frame is always accepted so that it can be discarded
    assign in_tready = admit_en &
                       (DROP_WHEN_FULL | ~full | frame_ovf | (state == ADMIT_DROP));
    assign accept    = in_tvalid & in_tready;
    assign wr_en     = accept & (state == ADMIT_STORE) & ~full & ~frame_ovf;
    assign wr_addr   = cur_ptr[ADDR_WIDTH-1:0];
    assign wr_data   = {in_tlast, in_tdata};

    always_comb begin
        event_next = EV_NONE;
        if (accept && in_tlast) begin
            if (in_tuser) begin
                event_next = EV_BAD;
            end else if (!wr_en) begin
                event_next = EV_OVERFLOW;
            end else begin
                event_next = EV_GOOD;
            end
        end
    end

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            admit_en     <= 1'b0;
            state        <= ADMIT_STORE;
            wr_ptr       <= '0;
            cur_ptr      <= '0;
            wr_ptr_gray  <= '0;
            in_event     <= EV_NONE;
            tog_good     <= 1'b0;
            tog_bad      <= 1'b0;
            tog_overflow <= 1'b0;
        end else begin
            admit_en     <= 1'b1;
            in_event     <= event_next;
            tog_good     <= tog_good ^ (event_next == EV_GOOD);
            tog_bad      <= tog_bad ^ (event_next == EV_BAD);
            tog_overflow <= tog_overflow ^ (event_next == EV_OVERFLOW);
            if (accept) begin
                if (in_tlast) begin
                    state <= ADMIT_STORE;
                    if (event_next == EV_GOOD) begin
                        // commit and publish the new frame end
                        cur_ptr     <= cur_inc;
                        wr_ptr      <= cur_inc;
                        wr_ptr_gray <= cur_inc ^ (cur_inc >> 1);
                    end else begin
                        // rollback to the last committed frame
                        cur_ptr <= wr_ptr;
                    end
                end else if (wr_en) begin
                    cur_ptr <= cur_inc;
                end else begin
                    state <= ADMIT_DROP;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_store.sv ====
`default_nettype none

module frame_store #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 8
) (
    input  wire                   async_rst,
    input  wire                   input_clk,
    input  wire                   output_clk,
    input  wire                   wr_en,
    input  wire [ADDR_WIDTH-1:0]  wr_addr,
    input  wire [DATA_WIDTH:0]    wr_data,
    input  wire [ADDR_WIDTH:0]    wr_ptr_gray,
    input  wire                   rd_en,
    input  wire [ADDR_WIDTH-1:0]  rd_addr,
    input  wire [ADDR_WIDTH:0]    rd_ptr_gray,
    output logic [DATA_WIDTH:0]   rd_data,
    output logic [ADDR_WIDTH:0]   wr_ptr_gray_sync,
    output logic [ADDR_WIDTH:0]   rd_ptr_gray_sync,
    output logic                  in_rst,
    output logic                  out_rst
);

    // each entry holds the last flag above the data
    logic [DATA_WIDTH:0]  mem [2**ADDR_WIDTH];
    logic [2:0]           in_rst_q;
    logic [2:0]           out_rst_q;
    logic [ADDR_WIDTH:0]  wr_gray_s1;
    logic [ADDR_WIDTH:0]  rd_gray_s1;

    // cross-coupled reset synchronizers
    // stage two of each domain waits for both first stages to clear
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_q <= 3'b111;
        end else begin
            in_rst_q[0] <= 1'b0;
            in_rst_q[1] <= in_rst_q[0] | out_rst_q[0];
            in_rst_q[2] <= in_rst_q[1];
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_q <= 3'b111;
        end else begin
            out_rst_q[0] <= 1'b0;
            out_rst_q[1] <= in_rst_q[0] | out_rst_q[0];
            out_rst_q[2] <= out_rst_q[1];
        end
    end

    assign in_rst  = in_rst_q[2];
    assign out_rst = out_rst_q[2];

    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data ready one cycle after rd_en
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // committed write pointer into the output domain
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_gray_s1       <= '0;
            wr_ptr_gray_sync <= '0;
        end else begin
            wr_gray_s1       <= wr_ptr_gray;
            wr_ptr_gray_sync <= wr_gray_s1;
        end
    end

    // read pointer back into the input domain
    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_gray_s1       <= '0;
            rd_ptr_gray_sync <= '0;
        end else begin
            rd_gray_s1       <= rd_ptr_gray;
            rd_ptr_gray_sync <= rd_gray_s1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_drain.sv ====
`default_nettype none

module frame_drain #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 8
) (
    input  wire                                   output_clk,
    input  wire                                   out_rst,
    input  wire [ADDR_WIDTH:0]                    wr_ptr_gray_sync,
    output logic                                  rd_en,
    output logic [ADDR_WIDTH-1:0]                 rd_addr,
    output logic [ADDR_WIDTH:0]                   rd_ptr_gray,
    input  wire [DATA_WIDTH:0]                    rd_data,
    output logic [DATA_WIDTH-1:0]                 out_tdata,
    output logic                                  out_tvalid,
    input  wire                                   out_tready,
    output logic                                  out_tlast,
    input  wire                                   tog_good,
    input  wire                                   tog_bad,
    input  wire                                   tog_overflow,
    output logic                                  out_good,
    output logic                                  out_bad,
    output logic                                  out_overflow,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_good,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_bad,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_overflow
);
    import frame_status_pkg::*;

    logic [ADDR_WIDTH:0]          rd_ptr;
    logic [ADDR_WIDTH:0]          rd_inc;
    logic                         empty;
    logic                         rd_valid;
    logic                         store_out;
    // bit positions follow the frame_event_t values
    logic [3:1]                   tog_in;
    logic [3:1]                   tog_s1;
    logic [3:1]                   tog_s2;
    logic [3:1]                   tog_s3;
    logic [3:1]                   pulse_q;
    logic [3:1][STAT_WIDTH-1:0]   cnt_q;

    assign rd_inc = rd_ptr + 1'b1;
    // only committed frames are visible through the synced pointer
    assign empty  = rd_ptr_gray == wr_ptr_gray_sync;

    // output register free or handing its beat over this cycle
    assign store_out = out_tready | ~out_tvalid;
    assign rd_en     = (store_out | ~rd_valid) & ~empty;
    assign rd_addr   = rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            rd_valid    <= 1'b0;
            out_tvalid  <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr      <= rd_inc;
                rd_ptr_gray <= rd_inc ^ (rd_inc >> 1);
            end
            if (store_out || !rd_valid) begin
                rd_valid <= ~empty;
            end
            if (store_out) begin
                out_tvalid <= rd_valid;
            end
        end
    end

    // payload of the output stage
    always_ff @(posedge output_clk) begin
        if (store_out) begin
            {out_tlast, out_tdata} <= rd_data;
        end
    end

    assign tog_in = {tog_overflow, tog_bad, tog_good};

    // toggle crossing, an edge between stages two and three is one event
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            tog_s1  <= '0;
            tog_s2  <= '0;
            tog_s3  <= '0;
            pulse_q <= '0;
            cnt_q   <= '0;
        end else begin
            tog_s1  <= tog_in;
            tog_s2  <= tog_s1;
            tog_s3  <= tog_s2;
            pulse_q <= tog_s2 ^ tog_s3;
            for (int i = 1; i <= 3; i++) begin
                if (tog_s2[i] ^ tog_s3[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign out_good     = pulse_q[EV_GOOD];
    assign out_bad      = pulse_q[EV_BAD];
    assign out_overflow = pulse_q[EV_OVERFLOW];
    assign cnt_good     = cnt_q[EV_GOOD];
    assign cnt_bad      = cnt_q[EV_BAD];
    assign cnt_overflow = cnt_q[EV_OVERFLOW];

endmodule

`default_nettype wire

// ==== logic/frame_fifo_top.sv ====
`default_nettype none

module frame_fifo_top #(
    parameter int ADDR_WIDTH     = 12,
    parameter int DATA_WIDTH     = 8,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  wire                                   async_rst,
    input  wire                                   input_clk,
    input  wire [DATA_WIDTH-1:0]                  in_tdata,
    input  wire                                   in_tvalid,
    output logic                                  in_tready,
    input  wire                                   in_tlast,
    input  wire                                   in_tuser,
    output frame_status_pkg::frame_event_t        in_event,
    input  wire                                   output_clk,
    output logic [DATA_WIDTH-1:0]                 out_tdata,
    output logic                                  out_tvalid,
    input  wire                                   out_tready,
    output logic                                  out_tlast,
    output logic                                  out_good,
    output logic                                  out_bad,
    output logic                                  out_overflow,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_good,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_bad,
    output logic [frame_status_pkg::STAT_WIDTH-1:0] cnt_overflow
);

    // input domain
    logic                   in_rst;
    logic                   wr_en;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [DATA_WIDTH:0]    wr_data;
    logic [ADDR_WIDTH:0]    wr_ptr_gray;
    logic [ADDR_WIDTH:0]    rd_ptr_gray_sync;
    logic                   tog_good;
    logic                   tog_bad;
    logic                   tog_overflow;

    // output domain
    logic                   out_rst;
    logic                   rd_en;
    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic [ADDR_WIDTH:0]    rd_ptr_gray;
    logic [DATA_WIDTH:0]    rd_data;
    logic [ADDR_WIDTH:0]    wr_ptr_gray_sync;

    frame_admit #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .DROP_WHEN_FULL (DROP_WHEN_FULL)
    ) u_admit (
        .input_clk        (input_clk),
        .in_rst           (in_rst),
        .in_tdata         (in_tdata),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tlast         (in_tlast),
        .in_tuser         (in_tuser),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_ptr_gray      (wr_ptr_gray),
        .in_event         (in_event),
        .tog_good         (tog_good),
        .tog_bad          (tog_bad),
        .tog_overflow     (tog_overflow)
    );

    frame_store #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_store (
        .async_rst        (async_rst),
        .input_clk        (input_clk),
        .output_clk       (output_clk),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_ptr_gray      (wr_ptr_gray),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_ptr_gray      (rd_ptr_gray),
        .rd_data          (rd_data),
        .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .rd_ptr_gray_sync (rd_ptr_gray_sync),
        .in_rst           (in_rst),
        .out_rst          (out_rst)
    );

    frame_drain #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_drain (
        .output_clk       (output_clk),
        .out_rst          (out_rst),
        .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_ptr_gray      (rd_ptr_gray),
        .rd_data          (rd_data),
        .out_tdata        (out_tdata),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tlast        (out_tlast),
        .tog_good         (tog_good),
        .tog_bad          (tog_bad),
        .tog_overflow     (tog_overflow),
        .out_good         (out_good),
        .out_bad          (out_bad),
        .out_overflow     (out_overflow),
        .cnt_good         (cnt_good),
        .cnt_bad          (cnt_bad),
        .cnt_overflow     (cnt_overflow)
    );

endmodule

`default_nettype wire

// ==== verif/frame_fifo_tb.sv ====
`default_nettype none

module frame_fifo_tb;
    import frame_status_pkg::*;

    localparam int ADDR_WIDTH  = 4;
    localparam int DATA_WIDTH  = 8;
    localparam int DEPTH       = 2 ** ADDR_WIDTH;
    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 3000;

    logic                  async_rst;
    logic                  input_clk;
    logic                  output_clk;
    logic [DATA_WIDTH-1:0] in_tdata;
    logic                  in_tvalid;
    logic                  in_tready;
    logic                  in_tlast;
    logic                  in_tuser;
    frame_event_t          in_event;
    logic [DATA_WIDTH-1:0] out_tdata;
    logic                  out_tvalid;
    logic                  out_tready;
    logic                  out_tlast;
    logic                  out_good;
    logic                  out_bad;
    logic                  out_overflow;
    logic [STAT_WIDTH-1:0] cnt_good;
    logic [STAT_WIDTH-1:0] cnt_bad;
    logic [STAT_WIDTH-1:0] cnt_overflow;

    integer                seed = 16960;
    int                    errors;
    int                    checks;
    int                    tot_good;
    int                    tot_bad;
    int                    tot_overflow;
    int                    pulse_good;
    int                    pulse_bad;
    int                    pulse_overflow;
    bit                    saw_backpressure;
    int                    frame_len[$];
    bit                    frame_flag[$];
    logic [DATA_WIDTH-1:0] frame_bytes[$];
    // last flag above the data, good frames only
    logic [DATA_WIDTH:0]   expected[$];

    frame_fifo_top #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .DROP_WHEN_FULL (1'b0)
    ) uut (
        .async_rst    (async_rst),
        .input_clk    (input_clk),
        .in_tdata     (in_tdata),
        .in_tvalid    (in_tvalid),
        .in_tready    (in_tready),
        .in_tlast     (in_tlast),
        .in_tuser     (in_tuser),
        .in_event     (in_event),
        .output_clk   (output_clk),
        .out_tdata    (out_tdata),
        .out_tvalid   (out_tvalid),
        .out_tready   (out_tready),
        .out_tlast    (out_tlast),
        .out_good     (out_good),
        .out_bad      (out_bad),
        .out_overflow (out_overflow),
        .cnt_good     (cnt_good),
        .cnt_bad      (cnt_bad),
        .cnt_overflow (cnt_overflow)
    );

    initial begin
        output_clk = 1'b0;
        forever #20 output_clk = ~output_clk;
    end

    initial begin
        input_clk = 1'b0;
        forever #13 input_clk = ~input_clk;
    end

    // expected outcome of one frame
    function automatic frame_event_t expected_outcome(input int len, input bit flag);
        if (flag) begin
            return EV_BAD;
        end else if (len > DEPTH) begin
            return EV_OVERFLOW;
        end
        return EV_GOOD;
    endfunction

    function automatic int rand_len(input int max_len);
        return 1 + int'($unsigned($random(seed)) % max_len);
    endfunction

    task automatic add_frame(input int len, input bit flag);
        frame_len.push_back(len);
        frame_flag.push_back(flag);
        for (int b = 0; b < len; b++) begin
            frame_bytes.push_back(DATA_WIDTH'($random(seed)));
        end
    endtask

    // all frames of all tests, drawn before the clocks start
    task automatic build_frames();
        for (int f = 0; f < 4; f++) begin
            add_frame(rand_len(DEPTH), 1'b0);
        end
        add_frame(rand_len(DEPTH), 1'b1);
        add_frame(rand_len(DEPTH), 1'b0);
        add_frame(rand_len(DEPTH), 1'b0);
        add_frame(DEPTH + rand_len(4), 1'b0);
        add_frame(rand_len(DEPTH), 1'b0);
        for (int f = 0; f < 24; f++) begin
            add_frame(rand_len(20), ($random(seed) % 4) == 0);
        end
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send_frame(input int len, input bit flag);
        frame_event_t          outcome;
        logic [DATA_WIDTH-1:0] data;
        bit                    ready_seen;
        int                    waited;
        outcome = expected_outcome(len, flag);
        case (outcome)
            EV_GOOD: tot_good++;
            EV_BAD:  tot_bad++;
            default: tot_overflow++;
        endcase
        @(posedge input_clk);
        for (int b = 0; b < len; b++) begin
            data = frame_bytes.pop_front();
            if (outcome == EV_GOOD) begin
                expected.push_back({(b == len - 1), data});
            end
            in_tdata  <= data;
            in_tvalid <= 1'b1;
            in_tlast  <= (b == len - 1);
            in_tuser  <= flag && (b == len - 1);
            ready_seen = 1'b0;
            waited = 0;
            // ready is stable mid-cycle, the beat moves on the next edge
            while (!ready_seen && waited < WAIT_LIMIT) begin
                @(negedge input_clk);
                ready_seen = in_tready;
                @(posedge input_clk);
                waited++;
            end
            if (!ready_seen) begin
                errors++;
                $display("in_tready stayed low for %0d cycles in the middle of a frame", waited);
                break;
            end
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
        in_tuser  <= 1'b0;
        @(negedge input_clk);
        if (ready_seen) begin
            compare_value("in_event", in_event, outcome);
        end
    endtask

    task automatic run_frames(input int count);
        for (int f = 0; f < count; f++) begin
            send_frame(frame_len.pop_front(), frame_flag.pop_front());
        end
    endtask

    task automatic check_idle(input bit in_reset);
        @(negedge output_clk);
        if (in_reset) begin
            compare_value("in_tready", in_tready, 0);
        end
        compare_value("out_tvalid", out_tvalid, 0);
        compare_value("cnt_good", cnt_good, 0);
        compare_value("cnt_bad", cnt_bad, 0);
        compare_value("cnt_overflow", cnt_overflow, 0);
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!in_tready && waited < WAIT_LIMIT) begin
            @(negedge input_clk);
            waited++;
        end
        if (!in_tready) begin
            errors++;
            $display("in_tready never rose after reset");
        end
    endtask

    // counters settle a few output cycles after the last frame leaves
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (waited < DRAIN_LIMIT && !(expected.size() == 0 && cnt_good == tot_good &&
               cnt_bad == tot_bad && cnt_overflow == tot_overflow &&
               pulse_good == tot_good && pulse_bad == tot_bad &&
               pulse_overflow == tot_overflow)) begin
            @(negedge output_clk);
            waited++;
        end
        if (expected.size() != 0) begin
            errors++;
            $display("%0d expected output beats never arrived", expected.size());
        end
        compare_value("cnt_good", cnt_good, tot_good);
        compare_value("cnt_bad", cnt_bad, tot_bad);
        compare_value("cnt_overflow", cnt_overflow, tot_overflow);
        compare_value("out_good pulses", pulse_good, tot_good);
        compare_value("out_bad pulses", pulse_bad, tot_bad);
        compare_value("out_overflow pulses", pulse_overflow, tot_overflow);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        out_tready = 1'b0;
        forever begin
            @(posedge output_clk);
            out_tready <= ($random(seed) % 2) != 0;
        end
    end

    always @(negedge input_clk) begin
        if (in_tvalid && !in_tready) begin
            saw_backpressure = 1'b1;
        end
    end

    // every cycle a pulse is high counts once
    always @(negedge output_clk) begin
        if (out_good) begin
            pulse_good++;
        end
        if (out_bad) begin
            pulse_bad++;
        end
        if (out_overflow) begin
            pulse_overflow++;
        end
    end

    // output comparator, the beat transfers on the following edge
    always @(negedge output_clk) begin : compare_output
        logic [DATA_WIDTH:0] head;
        if (out_tvalid && out_tready) begin
            if (expected.size() == 0) begin
                errors++;
                $display("unexpected output beat at time %0t with data %0h", $time, out_tdata);
            end else begin
                head = expected.pop_front();
                compare_value("out_tdata", out_tdata, head[DATA_WIDTH-1:0]);
                compare_value("out_tlast", out_tlast, head[DATA_WIDTH]);
            end
        end
    end

    initial begin
        int errors_before;
        async_rst = 1'b0;
        in_tdata  = '0;
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tuser  = 1'b0;
        errors = 0;
        checks = 0;
        tot_good = 0;
        tot_bad = 0;
        tot_overflow = 0;
        pulse_good = 0;
        pulse_bad = 0;
        pulse_overflow = 0;
        saw_backpressure = 1'b0;
        build_frames();

        errors_before = errors;
        @(posedge output_clk);
        async_rst <= 1'b1;
        repeat (3) @(posedge output_clk);
        check_idle(1'b1);
        @(posedge output_clk);
        async_rst <= 1'b0;
        wait_ready();
        check_idle(1'b0);
        finish_test("reset", errors_before);

        errors_before = errors;
        run_frames(4);
        wait_drained();
        finish_test("good frames", errors_before);

        errors_before = errors;
        run_frames(2);
        wait_drained();
        finish_test("bad frame", errors_before);

        errors_before = errors;
        run_frames(3);
        wait_drained();
        finish_test("oversized frame", errors_before);

        errors_before = errors;
        saw_backpressure = 1'b0;
        run_frames(24);
        if (!saw_backpressure) begin
            errors++;
            $display("in_tready never dropped during random traffic");
        end
        finish_test("random traffic", errors_before);

        errors_before = errors;
        wait_drained();
        @(negedge output_clk);
        compare_value("out_tvalid", out_tvalid, 0);
        finish_test("drain and counts", errors_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/frame_fifo_properties.sv ====
`default_nettype none

module frame_fifo_properties #(
    parameter int DATA_WIDTH = 8
) (
    input wire                  async_rst,
    input wire                  input_clk,
    input wire                  output_clk,
    input wire                  in_tready,
    input wire [DATA_WIDTH-1:0] out_tdata,
    input wire                  out_tvalid,
    input wire                  out_tready,
    input wire                  out_tlast
);

    // a stalled beat stays offered
    valid_held: assert property (
        @(posedge output_clk) disable iff (async_rst)
        out_tvalid && !out_tready |=> out_tvalid
    ) else $error("out_tvalid dropped before out_tready");

    stalled_stable: assert property (
        @(posedge output_clk) disable iff (async_rst)
        out_tvalid && !out_tready |=> $stable(out_tdata) && $stable(out_tlast)
    ) else $error("output beat changed while stalled");

    // no beats accepted while in reset
    ready_in_reset: assert property (
        @(posedge input_clk) async_rst |-> !in_tready
    ) else $error("in_tready high during reset");

endmodule

bind frame_fifo_top frame_fifo_properties #(
    .DATA_WIDTH (DATA_WIDTH)
) u_props (
    .async_rst  (async_rst),
    .input_clk  (input_clk),
    .output_clk (output_clk),
    .in_tready  (in_tready),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tlast  (out_tlast)
);

`default_nettype wire

// ==== sources.f ====
logic/fifo_geometry_pkg.sv
logic/frame_status_pkg.sv
logic/frame_admit.sv
logic/frame_store.sv
logic/frame_drain.sv
logic/frame_fifo_top.sv
verif/frame_fifo_tb.sv
verif/frame_fifo_properties.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module frame_fifo_tb \
    -f sources.f -o frame_fifo_sim
status=0
output=$(./obj_dir/frame_fifo_sim) || status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
printf '%s\n' "$output" | grep -qx "sim passed"
